// File: conv1.f
conv_pkg.sv
window_gen.sv
tap_multiply.sv
adder_tree.sv
bias_out.sv
conv1_top.sv
tb_conv1.sv

// File: tb_conv1.sv
`timescale 1ns/1ps

module tb_conv1
    import conv_pkg::*;
;

    localparam int unsigned seed        = 32'h5ebb_648d;
    localparam int          drain_limit = 200;   // cycles per drain wait
    localparam int          n_win       = (img_width - k_size + 1) * (img_height - k_size + 1);
    localparam int          mem_depth   = 1024;

    logic                              clk;
    logic                              rst_n;
    logic                              valid_in;
    logic [7:0]                        pix_in;
    weight_t [out_ch-1:0][n_taps-1:0]  weights;
    bias_t   [out_ch-1:0]              biases;
    logic                              valid_out;
    feat_t   [out_ch-1:0]              feat;

    // reference model state
    logic [7:0]          frame_pix [img_height][img_width];
    feat_t [out_ch-1:0]  exp_feat_mem [mem_depth];
    int                  exp_cycle_mem [mem_depth];  // cycle of the completing valid_in
    int                  exp_cnt    = 0;
    int                  out_idx    = 0;
    int                  cycle_cnt  = 0;
    int                  row        = 0;
    int                  col        = 0;
    logic                reset_seen = 1'b0;
    feat_t [out_ch-1:0]  exp_head;
    int                  exp_head_cycle;

    conv1_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .pix_in    (pix_in),
        .weights   (weights),
        .biases    (biases),
        .valid_out (valid_out),
        .feat      (feat)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    // ==================================================
    // reference model
    // ==================================================
    function automatic feat_t model_feat(input int ch, input int r, input int c);
        int          acc;
        logic [15:0] low;
        acc = 0;
        for (int i = 0; i < k_size; i++) begin
            for (int j = 0; j < k_size; j++) begin
                // tap i*5+j with row 0 and column 0 the oldest
                acc += int'(frame_pix[r-k_size+1+i][c-k_size+1+j])
                       * int'(weights[ch][i*k_size+j]);
            end
        end
        low = acc[15:0];
        return feat_t'(low + biases[ch]);  // 16-bit wrap
    endfunction

    task automatic send_pixel(input logic [7:0] p);
        @(negedge clk);
        valid_in = 1'b1;
        pix_in   = p;
        frame_pix[row][col] = p;
        if (row >= k_size - 1 && col >= k_size - 1) begin
            for (int ch = 0; ch < out_ch; ch++) begin
                exp_feat_mem[exp_cnt][ch] = model_feat(ch, row, col);
            end
            exp_cycle_mem[exp_cnt] = cycle_cnt;  // posedge about to take this pixel
            exp_cnt++;
        end
        if (col == img_width - 1) begin
            col = 0;
            row = (row == img_height - 1) ? 0 : row + 1;
        end else begin
            col++;
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        valid_in = 1'b0;
        pix_in   = 8'($urandom);  // junk payload the DUT must ignore
    endtask

    task automatic stream_frame(input bit gaps, input bit all_max);
        int         n_idle;
        logic [7:0] p;
        for (int i = 0; i < img_width * img_height; i++) begin
            n_idle = 0;
            if (gaps && ($urandom % 3 == 0)) n_idle = 1 + $urandom % 3;
            for (int k = 0; k < n_idle; k++) begin
                idle_cycle();
            end
            p = all_max ? 8'hff : 8'($urandom);
            send_pixel(p);
        end
        idle_cycle();
    endtask

    task automatic set_random_coefs();
        @(negedge clk);
        for (int c = 0; c < out_ch; c++) begin
            for (int t = 0; t < n_taps; t++) begin
                weights[c][t] = weight_t'($urandom);
            end
            biases[c] = bias_t'($urandom);
        end
    endtask

    task automatic set_extreme_coefs();
        @(negedge clk);
        for (int c = 0; c < out_ch; c++) begin
            for (int t = 0; t < n_taps; t++) begin
                weights[c][t] = (c % 2 == 0) ? 8'sd127 : -8'sd128;
            end
            biases[c] = (c % 3 == 0) ? 16'sh7fff : ((c % 3 == 1) ? 16'sh8000 : 16'sh7f00);
        end
    endtask

    // waits until the given number of frames has all its results out
    task automatic drain_and_count(input int frames);
        int t;
        t = 0;
        while (out_idx != frames * n_win && t < drain_limit) begin
            @(posedge clk);
            t++;
        end
        if (out_idx != frames * n_win) begin
            abort_run($sformatf("timeout: %0d results after %0d frames, want %0d",
                                out_idx, frames, frames * n_win));
        end
    endtask

    // ==================================================
    // output tracking and checks
    // ==================================================
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!rst_n) reset_seen <= 1'b1;
        if (rst_n && valid_out) out_idx <= out_idx + 1;
    end

    assign exp_head       = exp_feat_mem[out_idx % mem_depth];
    assign exp_head_cycle = exp_cycle_mem[out_idx % mem_depth];

    a_reset_quiet: assert property (
        @(posedge clk) (!rst_n && reset_seen) |-> !valid_out
    ) else abort_run($sformatf("Error at %0t: valid_out in reset expected 0 got %b",
                               $time, $sampled(valid_out)));

    a_no_extra: assert property (
        @(posedge clk) disable iff (!rst_n) valid_out |-> out_idx < exp_cnt
    ) else abort_run($sformatf("valid_out pulse with no result pending at %0t", $time));

    a_feat_match: assert property (
        @(posedge clk) disable iff (!rst_n) valid_out |-> feat == exp_head
    ) else abort_run($sformatf("Error at %0t: feat expected %h got %h",
                               $time, $sampled(exp_head), $sampled(feat)));

    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_out |-> cycle_cnt == exp_head_cycle + pipe_latency
    ) else abort_run($sformatf("Error at %0t: valid_out cycle expected %0d got %0d",
                               $time, $sampled(exp_head_cycle) + pipe_latency,
                               $sampled(cycle_cnt)));

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        rst_n    = 1'b0;
        valid_in = 1'b0;
        pix_in   = 8'h00;
        weights  = '0;
        biases   = '0;
        void'($urandom(seed));

        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
        end
        rst_n = 1'b1;
        for (int i = 0; i < 6; i++) begin
            idle_cycle();  // quiet stretch after reset
        end

        set_random_coefs();
        stream_frame(1'b0, 1'b0);
        drain_and_count(1);
        stream_frame(1'b0, 1'b0);  // second frame after the counters wrap
        drain_and_count(2);

        set_random_coefs();
        stream_frame(1'b1, 1'b0);  // idle gaps
        drain_and_count(3);

        set_extreme_coefs();
        stream_frame(1'b0, 1'b1);  // saturating inputs force the 16-bit wrap
        drain_and_count(4);

        for (int i = 0; i < pipe_latency; i++) begin
            @(negedge clk);  // room for a stray late pulse
        end

        if (out_idx == 4 * n_win) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run($sformatf("run ended with %0d results, want %0d", out_idx, 4 * n_win));
        end
    end

endmodule

// File: conv1_top.sv
`timescale 1ns/1ps

module conv1_top
    import conv_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              valid_in,
    input  logic [7:0]                        pix_in,
    input  weight_t [out_ch-1:0][n_taps-1:0]  weights,
    input  bias_t   [out_ch-1:0]              biases,
    output logic                              valid_out,
    output feat_t   [out_ch-1:0]              feat
);

    logic                            win_valid;
    pixel_t [n_taps-1:0]             window;
    logic                            prod_valid;
    prod_t  [out_ch-1:0][n_taps-1:0] products;
    logic   [out_ch-1:0]             tree_valid;   // all lanes in lockstep
    sum_t   [out_ch-1:0]             sums;

    // ==================================================
    // window and multiply
    // ==================================================
    window_gen u_window (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .pix_in    (pix_in),
        .win_valid (win_valid),
        .window    (window)
    );

    tap_multiply u_mult (
        .clk        (clk),
        .rst_n      (rst_n),
        .win_valid  (win_valid),
        .window     (window),
        .weights    (weights),
        .prod_valid (prod_valid),
        .products   (products)
    );

    // one tree per output channel
    for (genvar c = 0; c < out_ch; c++) begin : g_tree
        adder_tree u_tree (
            .clk       (clk),
            .rst_n     (rst_n),
            .valid_in  (prod_valid),
            .terms     (products[c]),
            .valid_out (tree_valid[c]),
            .sum       (sums[c])
        );
    end

    bias_out u_bias (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum_valid (tree_valid[0]),  // lane 0 stands for all
        .sums      (sums),
        .biases    (biases),
        .valid_out (valid_out),
        .feat      (feat)
    );

endmodule

// File: bias_out.sv
`timescale 1ns/1ps

module bias_out
    import conv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sum_valid,
    input  sum_t  [out_ch-1:0]    sums,
    input  bias_t [out_ch-1:0]    biases,
    output logic                  valid_out,
    output feat_t [out_ch-1:0]    feat
);

    feat_t [out_ch-1:0] acc;

    // low 16 bits of the sum plus bias, wraps in 16 bits
    always_comb begin
        for (int c = 0; c < out_ch; c++) begin
            acc[c] = feat_t'(sums[c][15:0] + biases[c]);
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            feat <= acc;  // holds between results
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= sum_valid;
        end
    end

    // catches X leaking from an unfilled window or line buffer
    a_feat_known: assert property (
        @(posedge clk) disable iff (!rst_n) valid_out |-> !$isunknown(feat)
    );

endmodule

// File: adder_tree.sv
`timescale 1ns/1ps

module adder_tree
    import conv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_in,
    input  prod_t [n_taps-1:0]    terms,
    output logic                  valid_out,
    output sum_t                  sum
);

    sum_t lvl1 [13];
    sum_t lvl2 [7];
    sum_t lvl3 [4];
    sum_t lvl4 [2];

    logic [tree_levels-1:0] valid_pipe;

    // ==================================================
    // reduction levels with the odd term passing straight down
    // ==================================================
    always_ff @(posedge clk) begin
        // 25 -> 13
        for (int i = 0; i < 12; i++) begin
            lvl1[i] <= sum_t'(prod_t'(terms[2*i])) + sum_t'(prod_t'(terms[2*i+1]));
        end
        lvl1[12] <= sum_t'(prod_t'(terms[24]));

        // 13 -> 7
        for (int i = 0; i < 6; i++) begin
            lvl2[i] <= lvl1[2*i] + lvl1[2*i+1];
        end
        lvl2[6] <= lvl1[12];

        // 7 -> 4
        for (int i = 0; i < 3; i++) begin
            lvl3[i] <= lvl2[2*i] + lvl2[2*i+1];
        end
        lvl3[3] <= lvl2[6];

        // 4 -> 2
        for (int i = 0; i < 2; i++) begin
            lvl4[i] <= lvl3[2*i] + lvl3[2*i+1];
        end

        sum <= lvl4[0] + lvl4[1];  // final level
    end

    // valid follows the data level by level
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[tree_levels-2:0], valid_in};
        end
    end

    assign valid_out = valid_pipe[tree_levels-1];

    a_tree_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_out == $past(valid_in, tree_levels)
    );

endmodule

// File: tap_multiply.sv
`timescale 1ns/1ps

module tap_multiply
    import conv_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  win_valid,
    input  pixel_t  [n_taps-1:0]                  window,
    input  weight_t [out_ch-1:0][n_taps-1:0]      weights,
    output logic                                  prod_valid,
    output prod_t   [out_ch-1:0][n_taps-1:0]      products
);

    prod_t [out_ch-1:0][n_taps-1:0] prod_comb;

    // ==================================================
    // 150 signed multiplies
    // ==================================================
    always_comb begin
        for (int c = 0; c < out_ch; c++) begin
            for (int t = 0; t < n_taps; t++) begin
                // signed multiply with the pixel top bit always 0
                prod_comb[c][t] = pixel_t'(window[t]) * weight_t'(weights[c][t]);
            end
        end
    end

    // product registers
    always_ff @(posedge clk) begin
        products <= prod_comb;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= win_valid;  // same one cycle as the data
        end
    end

endmodule

// File: window_gen.sv
`timescale 1ns/1ps

module window_gen
    import conv_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid_in,
    input  logic [7:0]                pix_in,
    output logic                      win_valid,
    output pixel_t [n_taps-1:0]       window
);

    // line_buf[0] is one row back, line_buf[k_size-2] is the oldest row
    logic [7:0] line_buf [k_size-1][img_width];

    logic [$clog2(img_width)-1:0]  col_cnt;
    logic [$clog2(img_height)-1:0] row_cnt;

    pixel_t [k_size-1:0] new_col;  // column entering the window with row 0 oldest
    logic                completing;

    // ==================================================
    // new column from the line buffer taps
    // ==================================================
    always_comb begin
        new_col[k_size-1] = pixel_t'({1'b0, pix_in});
        for (int r = 0; r < k_size - 1; r++) begin
            // row r sits (k_size-1-r) rows above the current one
            new_col[r] = pixel_t'({1'b0, line_buf[k_size-2-r][img_width-1]});
        end
    end

    assign completing = (row_cnt >= k_size - 1) && (col_cnt >= k_size - 1);

    // line buffers and window shift
    always_ff @(posedge clk) begin
        if (valid_in) begin
            for (int k = 0; k < k_size - 1; k++) begin
                for (int i = img_width - 1; i > 0; i--) begin
                    line_buf[k][i] <= line_buf[k][i-1];
                end
            end
            line_buf[0][0] <= pix_in;
            for (int k = 1; k < k_size - 1; k++) begin
                line_buf[k][0] <= line_buf[k-1][img_width-1];  // cascade rows
            end

            for (int r = 0; r < k_size; r++) begin
                for (int c = 0; c < k_size - 1; c++) begin
                    window[r*k_size+c] <= window[r*k_size+c+1];  // oldest drops out
                end
                window[r*k_size+k_size-1] <= new_col[r];
            end
        end
    end

    // ==================================================
    // raster position and window valid
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            win_valid <= 1'b0;
        end else begin
            win_valid <= valid_in && completing;
            if (valid_in) begin
                if (col_cnt == img_width - 1) begin
                    col_cnt <= '0;
                    // frame wrap
                    if (row_cnt == img_height - 1) row_cnt <= '0;
                    else                           row_cnt <= row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // a window only comes out of a pixel that was actually accepted
    a_win_needs_pixel: assert property (
        @(posedge clk) disable iff (!rst_n) !valid_in |=> !win_valid
    );

endmodule

// File: conv_pkg.sv
package conv_pkg;

    // ==================================================
    // frame geometry
    // ==================================================
    localparam int img_width  = 16;  // pixels per row
    localparam int img_height = 16;  // rows per frame

    // ==================================================
    // filter and pipeline shape
    // ==================================================
    localparam int k_size       = 5;              // filter side
    localparam int n_taps       = k_size * k_size;
    localparam int out_ch       = 6;              // LeNet-5 conv1 feature maps
    localparam int tree_levels  = 5;              // 25 -> 13 -> 7 -> 4 -> 2 -> 1

    // window reg + multiply reg + tree + bias reg
    localparam int pipe_latency = 1 + 1 + tree_levels + 1;

    // ==================================================
    // data types
    // ==================================================

    // 8-bit pixel with a zero on top, so it multiplies as signed
    typedef logic signed [8:0]  pixel_t;

    typedef logic signed [7:0]  weight_t;

    // 9 x 8 signed product
    typedef logic signed [16:0] prod_t;

    // 25 products need 5 more bits of headroom
    typedef logic signed [21:0] sum_t;

    typedef logic signed [15:0] bias_t;

    // low 16 bits of sum plus bias, wrapped
    typedef logic signed [15:0] feat_t;

endpackage
